// ==== sources.f ====
+incdir+dv
common/uart_bridge_pkg.sv
common/wb_if.sv
uart_rx/uart_rx.sv
logic/cmd_assembler.sv
logic/reg_bank.sv
logic/uart_bridge_top.sv
dv/tb_uart_bridge.sv

// ==== Makefile ====
SIM        = verilator
TOP        = tb_uart_bridge
FILELIST   = sources.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing -Wno-fatal
PASS_MSG   = sim passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# fails unless the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_uart_tasks.svh ====
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// ****************************************************************************
// serial line driving, every task starts and ends just after a rising edge
// ****************************************************************************

task automatic hold_line(input logic level, input int cycles);
    serial_in = level;
    repeat (cycles) @(posedge clk);
    #1;
endtask

task automatic idle_line(input int cycles);
    hold_line(1'b1, cycles);  // line idles high
endtask

// start bit, 8 data bits lsb first, then stop bit
task automatic drive_byte(input logic [7:0] data, input logic stop_level);
    hold_line(1'b0, bit_clks);
    for (int i = 0; i < 8; i++) begin
        hold_line(data[i], bit_clks);
    end
    hold_line(stop_level, bit_clks);
endtask

// opcode, address lsb first, data lsb first
task automatic send_frame(input logic [7:0] op, input logic [31:0] adr, input logic [31:0] dat);
    drive_byte(op, 1'b1);
    for (int i = 0; i < uart_bridge_pkg::word_bytes; i++) begin
        drive_byte(adr[i*8 +: 8], 1'b1);
    end
    for (int i = 0; i < uart_bridge_pkg::word_bytes; i++) begin
        drive_byte(dat[i*8 +: 8], 1'b1);
    end
endtask

// ****************************************************************************
// bounded waits on the monitor
// ****************************************************************************

task automatic wait_for_read(output logic [31:0] data, output bit ok);
    int t;
    ok   = 1'b0;
    data = '0;
    t    = 0;
    while (rd_seen.size() == 0 && t < read_timeout) begin
        @(posedge clk);
        #1;
        t++;
    end
    if (rd_seen.size() != 0) begin
        data = rd_seen.pop_front();
        ok   = 1'b1;
    end
endtask

task automatic wait_for_frame_err(input int prev, output bit ok);
    int t;
    t = 0;
    while (ferr_cnt == prev && t < read_timeout) begin
        @(posedge clk);
        #1;
        t++;
    end
    ok = (ferr_cnt != prev);
endtask

`endif

// ==== dv/tb_uart_bridge.sv ====
`timescale 1ns/1ps

module tb_uart_bridge;

    localparam int bit_clks     = uart_bridge_pkg::clks_per_bit;
    localparam int read_timeout = 4 * uart_bridge_pkg::clks_per_bit;
    localparam int bad_frames   = 4;

    logic        clk;
    logic        n_rst;
    logic        serial_in;
    logic [31:0] rd_data;
    logic        rd_valid;
    logic        frame_err;

    logic [31:0] model [uart_bridge_pkg::reg_count];  // expected register contents
    logic [31:0] rd_seen [$];   // rd_data at each rd_valid
    logic [31:0] last_rd;
    int          ferr_cnt;
    int          mismatches;
    int          timeouts;
    int          other_errs;

    uart_bridge_top dut0 (
        .clk       (clk),
        .n_rst     (n_rst),
        .serial_in (serial_in),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .frame_err (frame_err)
    );

    always #50 clk = ~clk;

    // sampled mid cycle, away from the drive edge
    always @(negedge clk) begin
        if (n_rst) begin
            if (rd_valid) begin
                rd_seen.push_back(rd_data);
            end
            if (frame_err) begin
                ferr_cnt++;
            end
        end
    end

    `include "tb_uart_tasks.svh"

    // ************************************************************************
    // reference model and frame level checks
    // ************************************************************************

    function automatic logic [3:0] model_idx(input logic [31:0] adr);
        return adr[5:2];    // upper bits alias
    endfunction

    task automatic write_word(input logic [31:0] adr, input logic [31:0] dat);
        logic [31:0] r;
        r = $urandom();
        send_frame({r[7:1], 1'b0}, adr, dat);
        model[model_idx(adr)] = dat;
    endtask

    task automatic read_check(input logic [31:0] adr);
        logic [31:0] r;
        logic [31:0] got;
        logic [31:0] exp;
        bit          ok;
        r   = $urandom();
        exp = model[model_idx(adr)];
        if (rd_seen.size() != 0) begin
            $display("rd_valid seen without a read frame, before read of %08h", adr);
            other_errs++;
            rd_seen.delete();
        end
        send_frame({r[7:1], 1'b1}, adr, $urandom());  // data bytes ignored
        wait_for_read(got, ok);
        if (!ok) begin
            $display("timeout waiting for rd_valid on read of address %08h", adr);
            timeouts++;
        end else begin
            last_rd = got;
            if (got !== exp) begin
                $display("[FAIL] rd_data expected %08h got %08h (adr %08h)", exp, got, adr);
                mismatches++;
            end
        end
    endtask

    // partial write frame cut short by a low stop bit
    task automatic bad_frame();
        logic [7:0]  frame [uart_bridge_pkg::frame_bytes];
        logic [31:0] r;
        logic [31:0] adr;
        logic [31:0] dat;
        int          bad_pos;
        int          prev_err;
        bit          ok;
        r        = $urandom();
        adr      = $urandom();
        dat      = $urandom();
        bad_pos  = $urandom_range(uart_bridge_pkg::frame_bytes - 1, 0);
        prev_err = ferr_cnt;
        frame[0] = {r[7:1], 1'b0};
        for (int i = 0; i < uart_bridge_pkg::word_bytes; i++) begin
            frame[1 + i] = adr[i*8 +: 8];
            frame[5 + i] = dat[i*8 +: 8];
        end
        for (int i = 0; i < bad_pos; i++) begin
            drive_byte(frame[i], 1'b1);
        end
        drive_byte(frame[bad_pos], 1'b0);
        idle_line(2 * bit_clks);
        wait_for_frame_err(prev_err, ok);
        if (!ok) begin
            $display("timeout waiting for frame_err after bad stop bit in byte %0d", bad_pos);
            timeouts++;
        end else if (ferr_cnt != prev_err + 1) begin
            $display("[FAIL] frame_err pulses expected %0h got %0h", 1, ferr_cnt - prev_err);
            mismatches++;
        end
        if (rd_seen.size() != 0) begin
            $display("rd_valid appeared for a discarded frame");
            other_errs++;
            rd_seen.delete();
        end
        read_check(adr);    // model must be untouched
    endtask

    // ************************************************************************
    // test sequence
    // ************************************************************************

    initial begin
        logic [31:0] r;
        logic [31:0] adr;
        logic [31:0] alias_adr;
        clk        = 1'b0;
        n_rst      = 1'b0;
        serial_in  = 1'b1;
        last_rd    = '0;
        ferr_cnt   = 0;
        mismatches = 0;
        timeouts   = 0;
        other_errs = 0;
        for (int i = 0; i < uart_bridge_pkg::reg_count; i++) begin
            model[i] = '0;
        end
        void'($urandom(60692));
        repeat (8) @(posedge clk);
        #1;
        n_rst = 1'b1;

        // quiet line after reset, all registers zero
        idle_line(4 * bit_clks);
        if (rd_seen.size() != 0 || ferr_cnt != 0) begin
            $display("rd_valid or frame_err pulsed with an idle line");
            other_errs++;
        end
        for (int i = 0; i < uart_bridge_pkg::reg_count; i++) begin
            r = $urandom();
            read_check({r[31:6], i[3:0], r[1:0]});
        end

        // write then read back
        for (int i = 0; i < 20; i++) begin
            adr = $urandom();
            write_word(adr, $urandom());
            idle_line($urandom_range(40, 1));
            read_check(adr);
        end

        // aliases above bit 5
        for (int i = 0; i < 8; i++) begin
            adr       = $urandom();
            r         = $urandom();
            alias_adr = {adr[31:6] ^ (r[31:6] | 26'd1), adr[5:0]};
            write_word(adr, $urandom());
            read_check(alias_adr);
        end

        for (int i = 0; i < bad_frames; i++) begin
            bad_frame();
        end

        // mixed traffic with idle gaps
        for (int i = 0; i < 60; i++) begin
            r   = $urandom();
            adr = $urandom();
            if (r[0]) begin
                read_check(adr);
            end else begin
                write_word(adr, $urandom());
            end
            idle_line($urandom_range(40, 1));
        end

        idle_line(4 * bit_clks);
        if (rd_seen.size() != 0) begin
            $display("rd_valid seen after the last read");
            other_errs++;
        end
        if (rd_data !== last_rd) begin
            $display("[FAIL] rd_data expected %08h got %08h (held)", last_rd, rd_data);
            mismatches++;
        end
        if (ferr_cnt != bad_frames) begin
            $display("[FAIL] frame_err count expected %0h got %0h", bad_frames, ferr_cnt);
            mismatches++;
        end

        $display("errors: %0d mismatches, %0d timeouts, %0d other",
                 mismatches, timeouts, other_errs);
        if (mismatches == 0 && timeouts == 0 && other_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== logic/uart_bridge_top.sv ====
`timescale 1ns/1ps

module uart_bridge_top (
    input  logic                              clk,
    input  logic                              n_rst,
    input  logic                              serial_in,
    output logic [uart_bridge_pkg::dat_w-1:0] rd_data,
    output logic                              rd_valid,
    output logic                              frame_err
);

    logic [7:0] rx_data;
    logic       rx_valid;

    wb_if bus ();

    // serial side
    uart_rx u_rx (
        .clk       (clk),
        .n_rst     (n_rst),
        .serial_in (serial_in),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_err    (frame_err)     // straight out as well
    );

    // frame to bus
    cmd_assembler u_asm (
        .clk      (clk),
        .n_rst    (n_rst),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_err   (frame_err),
        .bus      (bus.master),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

    reg_bank u_regs (
        .clk   (clk),
        .n_rst (n_rst),
        .bus   (bus.slave)
    );

endmodule

// ==== logic/reg_bank.sv ====
`timescale 1ns/1ps

module reg_bank (
    input  logic clk,
    input  logic n_rst,
    wb_if.slave  bus
);

    logic [uart_bridge_pkg::dat_w-1:0]     regs [uart_bridge_pkg::reg_count];
    logic [uart_bridge_pkg::reg_idx_w-1:0] idx;
    logic                                  req;
    logic                                  wr_en;

    // word index from adr[5:2], upper bits alias
    assign idx = bus.adr[uart_bridge_pkg::reg_idx_w+1:2];

    assign req   = bus.cyc && bus.stb;
    assign wr_en = req && bus.ack && bus.we;

    // ************************************************************************
    // one wait state handshake
    // ************************************************************************

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= req && !bus.ack;  // single cycle ack
        end
    end

    // ************************************************************************
    // register storage
    // ************************************************************************

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < uart_bridge_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[idx] <= bus.dat_w;   // commits on the ack edge
        end
    end

    // valid whenever ack is up
    assign bus.dat_r = regs[idx];

endmodule

// ==== logic/cmd_assembler.sv ====
`timescale 1ns/1ps

module cmd_assembler (
    input  logic                              clk,
    input  logic                              n_rst,
    input  logic [7:0]                        rx_data,
    input  logic                              rx_valid,
    input  logic                              rx_err,
    wb_if.master                              bus,
    output logic [uart_bridge_pkg::dat_w-1:0] rd_data,
    output logic                              rd_valid
);

    typedef logic [3:0] byte_cnt_t;

    uart_bridge_pkg::asm_state_e state;

    byte_cnt_t                         byte_cnt;   // bytes accepted so far
    logic [1:0]                        lane_idx;
    logic                              is_read;
    logic                              bus_active;
    logic [uart_bridge_pkg::adr_w-1:0] adr_q;
    logic [uart_bridge_pkg::dat_w-1:0] dat_q;
    logic [uart_bridge_pkg::dat_w-1:0] rd_q;

    // byte 1..4 address, 5..8 data, both lsb first
    assign lane_idx = 2'(byte_cnt - 4'd1);

    // ************************************************************************
    // frame collection
    // ************************************************************************

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state    <= uart_bridge_pkg::idle_op;
            byte_cnt <= '0;
            is_read  <= 1'b0;
        end else if (rx_err && state != uart_bridge_pkg::bus_cycle) begin
            state    <= uart_bridge_pkg::idle_op;   // drop partial frame
            byte_cnt <= '0;
        end else begin
            case (state)
                uart_bridge_pkg::idle_op: begin
                    if (rx_valid) begin
                        is_read  <= rx_data[uart_bridge_pkg::op_read_bit];
                        byte_cnt <= 4'd1;
                        state    <= uart_bridge_pkg::get_addr;
                    end
                end
                uart_bridge_pkg::get_addr: begin
                    if (rx_valid) begin
                        byte_cnt <= byte_cnt + 4'd1;
                        if (byte_cnt == byte_cnt_t'(uart_bridge_pkg::word_bytes)) begin
                            state <= uart_bridge_pkg::get_data;
                        end
                    end
                end
                uart_bridge_pkg::get_data: begin
                    if (rx_valid) begin
                        byte_cnt <= byte_cnt + 4'd1;
                        if (byte_cnt == byte_cnt_t'(uart_bridge_pkg::frame_bytes - 1)) begin
                            state <= uart_bridge_pkg::bus_cycle;   // ninth byte
                        end
                    end
                end
                uart_bridge_pkg::bus_cycle: begin
                    // line bytes ignored here
                    if (bus.ack) begin
                        state    <= uart_bridge_pkg::idle_op;
                        byte_cnt <= '0;
                    end
                end
                default: state <= uart_bridge_pkg::idle_op;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && state == uart_bridge_pkg::get_addr) begin
            adr_q[lane_idx*8 +: 8] <= rx_data;
        end
        if (rx_valid && state == uart_bridge_pkg::get_data) begin
            dat_q[lane_idx*8 +: 8] <= rx_data;
        end
    end

    // ************************************************************************
    // wishbone master
    // ************************************************************************

    assign bus_active = (state == uart_bridge_pkg::bus_cycle);

    assign bus.cyc   = bus_active;
    assign bus.stb   = bus_active;
    assign bus.we    = bus_active && !is_read;
    assign bus.adr   = adr_q;
    assign bus.dat_w = dat_q;

    // read result, live during ack then held
    assign rd_valid = bus_active && bus.ack && is_read;
    assign rd_data  = rd_valid ? bus.dat_r : rd_q;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rd_q <= '0;
        end else if (rd_valid) begin
            rd_q <= bus.dat_r;
        end
    end

endmodule

// ==== uart_rx/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
    input  logic       clk,
    input  logic       n_rst,
    input  logic       serial_in,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    output logic       rx_err
);

    typedef enum logic [2:0] {
        idle,
        start,
        receive,
        stop,
        error
    } rx_state_e;

    typedef logic [uart_bridge_pkg::baud_cnt_w-1:0] baud_cnt_t;

    rx_state_e state, n_state;

    logic       sync_q1;
    logic       rx_sync;     // synchronized line
    baud_cnt_t  baud_cnt;
    logic       baud_tick;
    logic [3:0] bit_cnt;
    logic       bit_done;
    logic       sample_bit;
    logic [7:0] shift_q;

    // ************************************************************************
    // input synchronizer, idles high like the line
    // ************************************************************************

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            sync_q1 <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            sync_q1 <= serial_in;
            rx_sync <= sync_q1;
        end
    end

    // ************************************************************************
    // baud and bit counters
    // ************************************************************************

    assign baud_tick  = (baud_cnt == '0);
    assign bit_done   = (bit_cnt == 4'd8);
    assign sample_bit = (state == receive) && baud_tick && !bit_done;

    // half a bit to the middle of start, then full bits
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            baud_cnt <= '0;
        end else if (state == idle || state == error) begin
            baud_cnt <= baud_cnt_t'(uart_bridge_pkg::half_bit - 1);
        end else if (baud_tick) begin
            baud_cnt <= baud_cnt_t'(uart_bridge_pkg::clks_per_bit - 1);
        end else begin
            baud_cnt <= baud_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            bit_cnt <= '0;
        end else if (state == idle) begin
            bit_cnt <= '0;
        end else if (sample_bit) begin
            bit_cnt <= bit_cnt + 4'd1;  // holds at 8
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (sample_bit) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
    end

    assign rx_data = shift_q;

    // ************************************************************************
    // receive FSM
    // ************************************************************************

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= idle;
        end else begin
            state <= n_state;
        end
    end

    always_comb begin
        n_state = state;
        case (state)
            idle: begin
                if (!rx_sync) begin
                    n_state = start;
                end
            end
            start: begin
                if (baud_tick) begin
                    n_state = rx_sync ? idle : receive;  // glitch, no error
                end
            end
            receive: begin
                if (bit_done) begin
                    n_state = stop;
                end
            end
            stop: begin
                if (baud_tick) begin
                    n_state = rx_sync ? idle : error;
                end
            end
            error: begin
                // hold off until the line is released
                if (rx_sync) begin
                    n_state = idle;
                end
            end
            default: n_state = idle;
        endcase
    end

    // one cycle pulses after the stop bit sample
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rx_valid <= 1'b0;
            rx_err   <= 1'b0;
        end else begin
            rx_valid <= (state == stop) && baud_tick && rx_sync;
            rx_err   <= (state == stop) && baud_tick && !rx_sync;
        end
    end

endmodule

// ==== common/wb_if.sv ====
`timescale 1ns/1ps

// single word wishbone classic, no byte selects
interface wb_if;

    logic [uart_bridge_pkg::adr_w-1:0] adr;
    logic [uart_bridge_pkg::dat_w-1:0] dat_w;
    logic [uart_bridge_pkg::dat_w-1:0] dat_r;
    logic                              we;
    logic                              cyc;
    logic                              stb;
    logic                              ack;

    modport master (
        output adr,
        output dat_w,
        output we,
        output cyc,
        output stb,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  adr,
        input  dat_w,
        input  we,
        input  cyc,
        input  stb,
        output dat_r,
        output ack
    );

endinterface

// ==== common/uart_bridge_pkg.sv ====
package uart_bridge_pkg;

    // ************************************************************************
    // serial line timing
    // ************************************************************************

    localparam int clks_per_bit = 16;              // short for sim
    localparam int half_bit     = clks_per_bit / 2; // start bit check point
    localparam int baud_cnt_w   = $clog2(clks_per_bit);

    // ************************************************************************
    // bus and frame layout
    // ************************************************************************

    localparam int adr_w = 32;
    localparam int dat_w = 32;

    // opcode, 4 address bytes, 4 data bytes
    localparam int frame_bytes = 9;
    localparam int word_bytes  = 4;

    localparam int op_read_bit = 0;  // set means read

    // register bank
    localparam int reg_count = 16;
    localparam int reg_idx_w = $clog2(reg_count);  // adr[5:2]

    // ************************************************************************
    // frame assembler states
    // ************************************************************************

    typedef enum logic [1:0] {
        idle_op,    // waiting for opcode byte
        get_addr,
        get_data,
        bus_cycle   // wishbone transfer in flight
    } asm_state_e;

endpackage
